/* memPkg.sv */
`default_nettype none

package memPkg;

    // datapath and address width
    localparam int dataWidth   = 32;
    localparam int byteWidth   = 8;                       // one lane of a word
    localparam int byteOffBits = 2;                       // byte offset inside a word

    // cache geometry: 2 ways, 8 sets, one word per line
    localparam int numWays   = 2;
    localparam int wayBits   = 1;                         // log2 of numWays
    localparam int numSets   = 8;
    localparam int indexBits = 3;                         // addr[4:2]
    localparam int tagBits   = dataWidth - indexBits - byteOffBits; // addr[31:5]

    // backing word RAM
    localparam int ramWords    = 4096;
    localparam int ramAddrBits = 12;                      // addr[13:2]

    // load/store access width
    typedef enum logic {
        modeWord = 1'b0,
        modeByte = 1'b1
    } addrModeE;

    // write-back source for the register file
    typedef enum logic [1:0] {
        resultAlu = 2'd0,
        resultMem = 2'd1,
        resultPc4 = 2'd2,
        resultImm = 2'd3
    } resultSrcE;

endpackage

`default_nettype wire

/* ram2port.sv */
`timescale 1ns/1ps
`default_nettype none

module ram2port import memPkg::*; (
    input  logic                 clk,
    input  logic [dataWidth-1:0] wAddr,   // byte address of the write-back word
    input  logic [dataWidth-1:0] wd,
    input  logic                 we,
    input  logic [dataWidth-1:0] rAddr,   // byte address, word aligned by the caller
    input  logic                 re,      // only high on a cache miss
    output logic [dataWidth-1:0] rd
);

    logic [dataWidth-1:0] mem [ramWords];  // plain storage, contents undefined at start

    logic [ramAddrBits-1:0] wWordAddr;
    logic [ramAddrBits-1:0] rWordAddr;

    assign wWordAddr = wAddr[byteOffBits +: ramAddrBits];  // drop byte offset
    assign rWordAddr = rAddr[byteOffBits +: ramAddrBits];

    // write port, evicted dirty lines land here
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wWordAddr] <= wd;
        end
    end

    // read port is asynchronous so a miss is served in the same cycle
    assign rd = re ? mem[rWordAddr] : '0;

endmodule

`default_nettype wire

/* cacheAccessCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheAccessCtrl import memPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 en,        // load or store in this cycle
    input  logic                 we,        // store
    input  logic [dataWidth-1:0] addr,
    input  logic [numWays-1:0]   hit,       // per-way tag match
    output logic [indexBits-1:0] index,
    output logic [tagBits-1:0]   tag,
    output logic [numWays-1:0]   lineWe,    // per-way line update strobe
    output logic [wayBits-1:0]   victim,    // lru way of the selected set
    output logic                 miss
);

    logic [wayBits-1:0] lruQ [numSets];    // holds the least recently used way per set
    logic [wayBits-1:0] hitWay;
    logic [wayBits-1:0] usedWay;

    // address split: | tag | index | byte offset |
    assign index = addr[byteOffBits +: indexBits];
    assign tag   = addr[dataWidth-1 -: tagBits];

    assign victim = lruQ[index];
    assign miss   = en && !(|hit);

    // encode the one-hot hit vector
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < numWays; w++) begin
            if (hit[w]) begin
                hitWay = wayBits'(w);
            end
        end
    end

    assign usedWay = miss ? victim : hitWay;  // the way touched by this access

    // store hit updates the hit way, any miss refills the victim
    always_comb begin
        for (int w = 0; w < numWays; w++) begin
            lineWe[w] = en && ((we && hit[w]) || (miss && victim == wayBits'(w)));
        end
    end

    // lru bookkeeping on every enabled access
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int s = 0; s < numSets; s++) begin
                lruQ[s] <= '0;
            end
        end else if (en) begin
            lruQ[index] <= ~usedWay;          // with two ways the other one becomes lru
        end
    end

endmodule

`default_nettype wire

/* cacheWay.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheWay import memPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [indexBits-1:0] index,
    input  logic [tagBits-1:0]   tag,
    input  logic                 lineWe,     // refill or store-hit update
    input  logic [dataWidth-1:0] newLine,
    input  logic                 newDirty,
    output logic                 hit,
    output logic [dataWidth-1:0] lineData,
    output logic [tagBits-1:0]   lineTag,
    output logic                 lineDirty,
    output logic                 lineValid
);

    logic [numSets-1:0]   validQ;            // control state, cleared on reset
    logic [numSets-1:0]   dirtyQ;
    logic [tagBits-1:0]   tagMem  [numSets];
    logic [dataWidth-1:0] dataMem [numSets];

    // lookup of the selected set
    assign lineValid = validQ[index];
    assign lineDirty = dirtyQ[index];
    assign lineTag   = tagMem[index];
    assign lineData  = dataMem[index];

    assign hit = lineValid && (lineTag == tag);

    // status bits
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= '0;
            dirtyQ <= '0;
        end else if (lineWe) begin
            validQ[index] <= 1'b1;
            dirtyQ[index] <= newDirty || (hit && lineDirty);  // a refresh never loses dirty
        end
    end

    // payload, tag and word
    always_ff @(posedge clk) begin
        if (lineWe) begin
            tagMem[index]  <= tag;
            dataMem[index] <= newLine;
        end
    end

endmodule

`default_nettype wire

/* waySelect.sv */
`timescale 1ns/1ps
`default_nettype none

module waySelect import memPkg::*; (
    input  addrModeE                           addrMode,
    input  logic                               we,
    input  logic [byteOffBits-1:0]             addrLow,   // byte lane
    input  logic [indexBits-1:0]               index,
    input  logic                               miss,
    input  logic [wayBits-1:0]                 victim,
    input  logic [numWays-1:0]                 hit,
    input  logic [numWays-1:0][dataWidth-1:0]  lineData,
    input  logic [numWays-1:0][tagBits-1:0]    lineTag,
    input  logic [numWays-1:0]                 lineDirty,
    input  logic [numWays-1:0]                 lineValid,
    input  logic [dataWidth-1:0]               wd,        // store value
    input  logic [dataWidth-1:0]               ramRd,     // refill word
    output logic [dataWidth-1:0]               rd,
    output logic [dataWidth-1:0]               newLine,
    output logic                               newDirty,
    output logic                               ramWe,
    output logic [dataWidth-1:0]               ramWAddr,
    output logic [dataWidth-1:0]               ramWd
);

    logic [dataWidth-1:0] hitWord;
    logic [dataWidth-1:0] oldWord;
    logic [dataWidth-1:0] mergedWord;
    logic [byteWidth-1:0] loadByte;

    // at most one way hits
    always_comb begin
        hitWord = '0;
        for (int w = 0; w < numWays; w++) begin
            if (hit[w]) begin
                hitWord = lineData[w];
            end
        end
    end

    assign oldWord  = miss ? ramRd : hitWord;                     // word before this access
    assign loadByte = oldWord[addrLow*byteWidth +: byteWidth];

    assign rd = (addrMode == modeByte) ? {{(dataWidth-byteWidth){1'b0}}, loadByte} : oldWord;

    // store merge, only the addressed lane changes in byte mode
    always_comb begin
        mergedWord = oldWord;
        mergedWord[addrLow*byteWidth +: byteWidth] = wd[byteWidth-1:0];
    end

    always_comb begin
        if (!we) begin
            newLine = oldWord;                                    // load fill keeps ram word
        end else if (addrMode == modeByte) begin
            newLine = mergedWord;
        end else begin
            newLine = wd;
        end
    end

    assign newDirty = we;

    // dirty victim goes back to ram at the refill edge
    assign ramWe    = miss && lineValid[victim] && lineDirty[victim];
    assign ramWAddr = {lineTag[victim], index, {byteOffBits{1'b0}}};  // rebuilt byte address
    assign ramWd    = lineData[victim];

endmodule

`default_nettype wire

/* cacheTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheTop import memPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 en,         // memory instruction this cycle
    input  addrModeE             addrMode,
    input  logic                 we,
    input  logic [dataWidth-1:0] addr,
    input  logic [dataWidth-1:0] wd,
    input  logic [dataWidth-1:0] ramRd,
    output logic [dataWidth-1:0] rd,
    output logic                 ramRe,      // ram read only on a miss
    output logic                 ramWe,
    output logic [dataWidth-1:0] ramWAddr,
    output logic [dataWidth-1:0] ramWd
);

    logic [indexBits-1:0]              index;
    logic [tagBits-1:0]                tag;
    logic [numWays-1:0]                lineWe;
    logic [wayBits-1:0]                victim;
    logic                              miss;
    logic [numWays-1:0]                hit;
    logic [numWays-1:0][dataWidth-1:0] lineData;
    logic [numWays-1:0][tagBits-1:0]   lineTag;
    logic [numWays-1:0]                lineDirty;
    logic [numWays-1:0]                lineValid;
    logic [dataWidth-1:0]              newLine;
    logic                              newDirty;

    assign ramRe = miss;

    cacheAccessCtrl cacheAccessCtrl_inst (
        .clk(clk), .rstN(rstN), .en(en), .we(we), .addr(addr), .hit(hit),
        .index(index), .tag(tag), .lineWe(lineWe), .victim(victim), .miss(miss)
    );

    // identical ways, same index and tag, own strobe
    for (genvar w = 0; w < numWays; w++) begin : genWay
        cacheWay cacheWay_inst (
            .clk(clk), .rstN(rstN), .index(index), .tag(tag),
            .lineWe(lineWe[w]), .newLine(newLine), .newDirty(newDirty),
            .hit(hit[w]), .lineData(lineData[w]), .lineTag(lineTag[w]),
            .lineDirty(lineDirty[w]), .lineValid(lineValid[w])
        );
    end

    waySelect waySelect_inst (
        .addrMode(addrMode), .we(we), .addrLow(addr[byteOffBits-1:0]), .index(index),
        .miss(miss), .victim(victim), .hit(hit), .lineData(lineData),
        .lineTag(lineTag), .lineDirty(lineDirty), .lineValid(lineValid),
        .wd(wd), .ramRd(ramRd), .rd(rd), .newLine(newLine), .newDirty(newDirty),
        .ramWe(ramWe), .ramWAddr(ramWAddr), .ramWd(ramWd)
    );

endmodule

`default_nettype wire

/* memoryTop.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryTop import memPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  addrModeE             addrMode,   // word or byte access
    input  resultSrcE            resultSrc,  // from control unit
    input  logic                 memWrite,
    input  logic [dataWidth-1:0] pcPlus4,
    input  logic [dataWidth-1:0] immExt,
    input  logic [dataWidth-1:0] aluResult,  // effective address for loads/stores
    input  logic [dataWidth-1:0] writeData,  // store value from register file
    output logic [dataWidth-1:0] result      // to register file write port
);

    logic [dataWidth-1:0] readData;
    logic                 cacheEn;
    logic                 ramRe;
    logic                 ramWe;
    logic [dataWidth-1:0] ramWAddr;
    logic [dataWidth-1:0] ramWd;
    logic [dataWidth-1:0] ramRd;
    logic [dataWidth-1:0] ramRAddr;

    // other instructions must not cause fills or evictions
    assign cacheEn = (resultSrc == resultMem) || memWrite;

    // ram works on whole words, byte lanes are handled in the cache
    assign ramRAddr = {aluResult[dataWidth-1:byteOffBits], {byteOffBits{1'b0}}};

    cacheTop cacheTop_inst (
        .clk(clk), .rstN(rstN), .en(cacheEn), .addrMode(addrMode), .we(memWrite),
        .addr(aluResult), .wd(writeData), .ramRd(ramRd), .rd(readData),
        .ramRe(ramRe), .ramWe(ramWe), .ramWAddr(ramWAddr), .ramWd(ramWd)
    );

    ram2port ram2port_inst (
        .clk(clk), .wAddr(ramWAddr), .wd(ramWd), .we(ramWe),
        .rAddr(ramRAddr), .re(ramRe), .rd(ramRd)
    );

    // write-back source select
    always_comb begin
        case (resultSrc)
            resultAlu: result = aluResult;
            resultMem: result = readData;
            resultPc4: result = pcPlus4;
            resultImm: result = immExt;
            default:   result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* memoryTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryTb import memPkg::*; ();

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 5;
    localparam int poolWords   = 32;                  // 4 tags x 8 sets, all inside the ram
    localparam int numDirected = 26;                  // ops of the directed sequences
    localparam int numRandom   = 400;
    localparam int totalOps    = poolWords + numDirected + numRandom;
    localparam int timeoutNs   = (totalOps + resetCycles + 10) * clkPeriod + 500;

    logic                 clk;
    logic                 rstN;
    addrModeE             addrMode;
    resultSrcE            resultSrc;
    logic                 memWrite;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] writeData;
    logic [dataWidth-1:0] result;

    logic [dataWidth-1:0] model [poolWords];          // reference memory, word granular
    logic [dataWidth-1:0] expResult;                   // expected result of the current op
    logic                 checkEn;
    logic [31:0]          rngState;
    int                   opCount;
    int                   checkCount;

    always #(clkPeriod / 2) clk = ~clk;

    memoryTop memoryTop_inst (
        .clk(clk), .rstN(rstN), .addrMode(addrMode), .resultSrc(resultSrc),
        .memWrite(memWrite), .pcPlus4(pcPlus4), .immExt(immExt),
        .aluResult(aluResult), .writeData(writeData), .result(result)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;     // numerical recipes constants
    endfunction

    // byte address of a pool word, tag in bits 6:5 so sets conflict
    function automatic logic [31:0] poolAddr(input logic [1:0] tag, input logic [2:0] set,
                                             input logic [1:0] lane);
        return {25'b0, tag, set, lane};
    endfunction

    // expected write-back value from the source select and the model
    function automatic logic [31:0] refResult(input resultSrcE src, input addrModeE mode,
                                              input logic [31:0] addr, input logic [31:0] pc4,
                                              input logic [31:0] imm);
        logic [31:0] word;
        word = model[addr[6:2]];
        case (src)
            resultMem: begin
                if (mode == modeByte) return {24'b0, word[addr[1:0]*8 +: 8]};  // zero-extended
                return word;
            end
            resultPc4: return pc4;
            resultImm: return imm;
            default:   return addr;
        endcase
    endfunction

    task automatic updateModel(input addrModeE mode, input logic [31:0] addr,
                               input logic [31:0] data);
        if (mode == modeByte) begin
            model[addr[6:2]][addr[1:0]*8 +: 8] = data[7:0];  // only the addressed lane
        end else begin
            model[addr[6:2]] = data;
        end
    endtask

    // one instruction per cycle, expected value taken before the model changes
    task automatic applyOp(input addrModeE mode, input resultSrcE src, input logic we,
                           input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] pc4;
        logic [31:0] imm;
        rngState = lcgNext(rngState);
        pc4 = rngState;
        rngState = lcgNext(rngState);
        imm = rngState;
        @(posedge clk);
        addrMode  <= mode;
        resultSrc <= src;
        memWrite  <= we;
        aluResult <= addr;
        writeData <= data;
        pcPlus4   <= pc4;
        immExt    <= imm;
        expResult = refResult(src, mode, addr, pc4, imm);
        checkEn   = 1'b1;
        opCount++;
        if (we) updateModel(mode, addr, data);
    endtask

    // compare just before the edge that commits the op
    always @(posedge clk) begin
        #(clkPeriod - 1);
        if (checkEn) begin
            checkCount++;
            assert (result === expResult) else begin
                $display("[ERROR] %0t ns: result mismatch at addr 0x%08h, exp 0x%08h, got 0x%08h",
                         $time, aluResult, expResult, result);
                $display("TEST FAILED");
                $fatal(1, "result mismatch");
            end
        end
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the test did not finish within %0d ns", timeoutNs);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        addrModeE    mode;
        clk        = 1'b0;
        rstN       = 1'b0;
        addrMode   = modeWord;
        resultSrc  = resultAlu;                       // keeps the cache idle in reset
        memWrite   = 1'b0;
        pcPlus4    = '0;
        immExt     = '0;
        aluResult  = '0;
        writeData  = '0;
        checkEn    = 1'b0;
        rngState   = 32'd71761;
        opCount    = 0;
        checkCount = 0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;

        // every pool word gets a defined value before any load
        for (int i = 0; i < poolWords; i++) begin
            rngState = lcgNext(rngState);
            applyOp(modeWord, resultAlu, 1'b1, poolAddr(i[4:3], i[2:0], 2'd0), rngState);
        end

        // store, hit load, evict by two conflicting tags, miss load, hit load
        applyOp(modeWord, resultAlu, 1'b1, poolAddr(2'd0, 3'd1, 2'd0), 32'hdead_beef);
        applyOp(modeWord, resultMem, 1'b0, poolAddr(2'd0, 3'd1, 2'd0), '0);
        applyOp(modeWord, resultAlu, 1'b1, poolAddr(2'd1, 3'd1, 2'd0), 32'h1111_2222);
        applyOp(modeWord, resultAlu, 1'b1, poolAddr(2'd2, 3'd1, 2'd0), 32'h3333_4444);
        applyOp(modeWord, resultMem, 1'b0, poolAddr(2'd0, 3'd1, 2'd0), '0);
        applyOp(modeWord, resultMem, 1'b0, poolAddr(2'd0, 3'd1, 2'd0), '0);

        // three stores into set 5, then read all four tags back
        for (int t = 0; t < 3; t++) begin
            applyOp(modeWord, resultAlu, 1'b1, poolAddr(t[1:0], 3'd5, 2'd0), 32'h5500_0000 + t);
        end
        for (int t = 0; t < 4; t++) begin
            applyOp(modeWord, resultMem, 1'b0, poolAddr(t[1:0], 3'd5, 2'd0), '0);
        end

        // byte store into lane 2, byte loads of all lanes, word load
        applyOp(modeByte, resultAlu, 1'b1, poolAddr(2'd3, 3'd6, 2'd2), 32'h0000_00a5);
        for (int l = 0; l < 4; l++) begin
            applyOp(modeByte, resultMem, 1'b0, poolAddr(2'd3, 3'd6, l[1:0]), '0);
        end
        applyOp(modeWord, resultMem, 1'b0, poolAddr(2'd3, 3'd6, 2'd0), '0);

        // non-memory sources must leave the cache and ram alone
        applyOp(modeWord, resultAlu, 1'b0, poolAddr(2'd2, 3'd3, 2'd0), 32'hffff_ffff);
        applyOp(modeWord, resultPc4, 1'b0, poolAddr(2'd0, 3'd3, 2'd0), 32'hffff_ffff);
        applyOp(modeByte, resultImm, 1'b0, poolAddr(2'd1, 3'd3, 2'd1), 32'hffff_ffff);
        for (int t = 0; t < 4; t++) begin
            applyOp(modeWord, resultMem, 1'b0, poolAddr(t[1:0], 3'd3, 2'd0), '0);
        end

        // random mix over the conflicting pool
        for (int i = 0; i < numRandom; i++) begin
            rngState = lcgNext(rngState);
            r = rngState;
            rngState = lcgNext(rngState);
            d = rngState;
            mode = r[29] ? modeByte : modeWord;
            if (mode == modeWord) r[23:22] = 2'd0;     // word ops stay aligned
            case (r[31:30])
                2'b10: applyOp(mode, resultAlu, 1'b1, poolAddr(r[28:27], r[26:24], r[23:22]), d);
                2'b11: applyOp(mode, resultSrcE'(r[21:20]), 1'b0,
                               poolAddr(r[28:27], r[26:24], r[23:22]), d);
                default: applyOp(mode, resultMem, 1'b0,
                                 poolAddr(r[28:27], r[26:24], r[23:22]), d);
            endcase
        end

        @(posedge clk);
        memWrite  <= 1'b0;
        resultSrc <= resultAlu;
        checkEn   = 1'b0;                             // last compare already ran
        @(posedge clk);
        if (checkCount == opCount) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("Only %0d of %0d results were compared", checkCount, opCount);
            $display("TEST FAILED");
            $fatal(1, "incomplete run");
        end
    end

endmodule

`default_nettype wire

/* flist.f */
memPkg.sv
ram2port.sv
cacheAccessCtrl.sv
cacheWay.sv
waySelect.sv
cacheTop.sv
memoryTop.sv
memoryTb.sv
